// File: src.f
design/mac_tx_pkg.sv
design/crc32_gen.sv
design/tx_queue_arbiter.sv
design/tx_frame_sender.sv
design/ptp_tx_monitor.sv
design/mac_tx_top.sv
dv/mac_tx_tb.sv

// File: Bender.yml
package:
  name: mac_tx

sources:
  - design/mac_tx_pkg.sv
  - design/crc32_gen.sv
  - design/tx_queue_arbiter.sv
  - design/tx_frame_sender.sv
  - design/ptp_tx_monitor.sv
  - design/mac_tx_top.sv
  - target: test
    files:
      - dv/mac_tx_tb.sv

// File: dv/mac_tx_tb.sv
`timescale 1ns/100ps

module mac_tx_tb;
    import mac_tx_pkg::*;

    localparam int TIMEOUT_CYCLES = 3000;   // all frames plus gaps, doubled

    logic        tx_master_clk;
    logic        rstn_mac;
    logic        ptr_fifo_rd;
    logic        tptr_fifo_rd;
    logic        data_fifo_rd;
    logic        tdata_fifo_rd;
    ptr_word_t   ptr_fifo_din;
    ptr_word_t   tptr_fifo_din;
    logic        ptr_fifo_empty;
    logic        tptr_fifo_empty;
    byte_t       data_fifo_din;
    byte_t       tdata_fifo_din;
    logic        data_fifo_empty;
    logic        tdata_fifo_empty;
    logic [31:0] counter_ns;
    ptp_delay_t  counter_delay;
    gmii_tx_t    gmii;

    ptr_word_t   ptr_q[$];
    ptr_word_t   tptr_q[$];
    byte_t       data_q[$];
    byte_t       tdata_q[$];
    logic        rd_ptr = 1'b0;     // strobes seen in the current cycle
    logic        rd_tptr = 1'b0;
    logic        rd_data = 1'b0;
    logic        rd_tdata = 1'b0;

    byte_t       rx_bytes[$];       // every gmii byte with dv high
    int          burst_len[$];
    int          cur_len = 0;
    int          idle_cnt = 0;
    bit          seen_burst = 1'b0;
    byte_t       frame_buf[$];
    ptp_delay_t  exp_delay;
    int          seed = 32'hf08ac43d;
    int          cycles = 0;

    mac_tx_top DUT (
        .tx_master_clk    (tx_master_clk),
        .rstn_mac         (rstn_mac),
        .ptr_fifo_rd      (ptr_fifo_rd),
        .ptr_fifo_din     (ptr_fifo_din),
        .ptr_fifo_empty   (ptr_fifo_empty),
        .data_fifo_rd     (data_fifo_rd),
        .data_fifo_din    (data_fifo_din),
        .data_fifo_empty  (data_fifo_empty),
        .tptr_fifo_rd     (tptr_fifo_rd),
        .tptr_fifo_din    (tptr_fifo_din),
        .tptr_fifo_empty  (tptr_fifo_empty),
        .tdata_fifo_rd    (tdata_fifo_rd),
        .tdata_fifo_din   (tdata_fifo_din),
        .tdata_fifo_empty (tdata_fifo_empty),
        .counter_ns       (counter_ns),
        .counter_delay    (counter_delay),
        .gmii             (gmii)
    );

    initial tx_master_clk = 1'b0;
    always #50 tx_master_clk = ~tx_master_clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compare_byte(input string name, input byte_t exp, input byte_t got);
        if (got !== exp)
            report_failure($sformatf("error %s expected 0x%h got 0x%h", name, exp, got));
    endtask

    task automatic compare_delay(input string name, input ptp_delay_t exp,
                                 input ptp_delay_t got);
        if (got !== exp)
            report_failure($sformatf("error %s expected 0x%h got 0x%h", name, exp, got));
    endtask

    task automatic compare_count(input string name, input int exp, input int got);
        if (got != exp)
            report_failure($sformatf("error %s expected 0x%h got 0x%h", name, exp, got));
    endtask

    //////////////////////////////////////////////////////////////////////
    // fifo models, registered outputs
    //////////////////////////////////////////////////////////////////////
    always @(negedge tx_master_clk) begin
        rd_ptr   = ptr_fifo_rd;
        rd_tptr  = tptr_fifo_rd;
        rd_data  = data_fifo_rd;
        rd_tdata = tdata_fifo_rd;
    end

    always @(posedge tx_master_clk) begin
        #5;
        if (rd_ptr && ptr_q.size() == 0)
            report_failure("pointer read from the empty normal queue");
        else if (rd_tptr && tptr_q.size() == 0)
            report_failure("pointer read from the empty tte queue");
        else if (rd_data && data_q.size() == 0)
            report_failure("data read from the empty normal queue");
        else if (rd_tdata && tdata_q.size() == 0)
            report_failure("data read from the empty tte queue");
        else begin
            if (rd_ptr)
                ptr_fifo_din = ptr_q.pop_front();
            if (rd_tptr)
                tptr_fifo_din = tptr_q.pop_front();
            if (rd_data)
                data_fifo_din = data_q.pop_front();
            if (rd_tdata)
                tdata_fifo_din = tdata_q.pop_front();
            ptr_fifo_empty   = (ptr_q.size() == 0);
            tptr_fifo_empty  = (tptr_q.size() == 0);
            data_fifo_empty  = (data_q.size() == 0);
            tdata_fifo_empty = (tdata_q.size() == 0);
        end
    end

    // gmii monitor, splits dv bursts and watches the gap
    always @(negedge tx_master_clk) begin
        if (rstn_mac) begin
            if (gmii.dv) begin
                if (cur_len == 0 && seen_burst && idle_cnt < IFG_LEN)
                    report_failure("interframe gap shorter than 12 cycles");
                else begin
                    rx_bytes.push_back(gmii.d);
                    cur_len++;
                    idle_cnt = 0;
                end
            end else begin
                if (cur_len != 0) begin
                    burst_len.push_back(cur_len);
                    cur_len    = 0;
                    seen_burst = 1'b1;
                end
                idle_cnt++;
            end
        end
    end

    always @(posedge tx_master_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
            report_failure("timeout, the DUT did not finish all frames in time");
    end

    // 802.3 crc in its serial form, bits in wire order, msb-first register
    function automatic logic [31:0] ref_crc(input byte_t bytes[$]);
        logic [31:0] c;
        logic [31:0] r;
        logic        fb;
        c = 32'hffff_ffff;
        foreach (bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[31] ^ bytes[i][b];
                c  = {c[30:0], 1'b0} ^ (fb ? 32'h04c1_1db7 : 32'h0);
            end
        end
        // fcs goes out x^31 first, so bit 0 of the result is c[31]
        for (int b = 0; b < 32; b++)
            r[b] = ~c[31-b];
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // frame helpers
    //////////////////////////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge tx_master_clk);
        #5;
    endtask

    task automatic make_frame(input int len);
        frame_buf.delete();
        for (int i = 0; i < len; i++)
            frame_buf.push_back(byte_t'($random(seed)));
        if (len > 13) begin
            frame_buf[12] = 8'h08;  // ipv4, never ptp by accident
            frame_buf[13] = 8'h00;
        end
    endtask

    task automatic set_ptp(input ptp_msg_e msg);
        frame_buf[12] = 8'h88;
        frame_buf[13] = 8'hf7;
        frame_buf[14] = {4'h0, msg};
    endtask

    task automatic set_stamp(input logic [31:0] ts);
        frame_buf[54] = ts[31:24];  // big endian ns
        frame_buf[55] = ts[23:16];
        frame_buf[56] = ts[15:8];
        frame_buf[57] = ts[7:0];
    endtask

    // data first, pointer last, like the upstream writer
    task automatic queue_frame(input bit tte);
        ptr_word_t p;
        p     = ptr_word_t'($random(seed));
        p.len = frame_len_t'(frame_buf.size());
        foreach (frame_buf[i]) begin
            if (tte)
                tdata_q.push_back(frame_buf[i]);
            else
                data_q.push_back(frame_buf[i]);
        end
        if (tte)
            tptr_q.push_back(p);
        else
            ptr_q.push_back(p);
    endtask

    task automatic check_burst(input byte_t exp[$]);
        int          n;
        logic [31:0] c;
        while (burst_len.size() == 0)
            next_cycle();
        n = burst_len.pop_front();
        compare_count("burst_len", exp.size() + PREAMBLE_LEN + CRC_LEN, n);
        for (int i = 0; i < 7; i++)
            compare_byte("gmii.d", 8'h55, rx_bytes.pop_front());
        compare_byte("gmii.d", 8'hd5, rx_bytes.pop_front());
        foreach (exp[i])
            compare_byte("gmii.d", exp[i], rx_bytes.pop_front());
        c = ref_crc(exp);
        for (int i = 0; i < 4; i++)
            compare_byte("gmii.d", c[8*i +: 8], rx_bytes.pop_front());   // low byte first
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic test_single_frame();
        next_cycle();
        make_frame(64);
        queue_frame(1'b0);
        check_burst(frame_buf);
    endtask

    task automatic test_tte_priority();
        byte_t norm[$];
        next_cycle();
        make_frame(48);
        norm = frame_buf;
        queue_frame(1'b0);
        make_frame(40);
        queue_frame(1'b1);      // same time step as the normal one
        check_burst(frame_buf);
        check_burst(norm);
    endtask

    task automatic test_back_to_back();
        byte_t f1[$];
        byte_t f2[$];
        next_cycle();
        make_frame(1);
        f1 = frame_buf;
        queue_frame(1'b0);
        make_frame(60);
        f2 = frame_buf;
        queue_frame(1'b0);
        make_frame(200);
        queue_frame(1'b0);
        check_burst(f1);
        check_burst(f2);
        check_burst(frame_buf);
    endtask

    task automatic test_ptp_sync();
        next_cycle();
        counter_ns = 32'h0000_1000;     // below the stamp, result wraps
        make_frame(64);
        set_ptp(PTP_SYNC);
        set_stamp(32'h3b9a_c9ff);
        queue_frame(1'b0);
        exp_delay.sync_ns = 32'h0000_1000 - 32'h3b9a_c9ff;
        check_burst(frame_buf);
        compare_delay("counter_delay", exp_delay, counter_delay);
    endtask

    task automatic test_ptp_delay_req();
        next_cycle();
        counter_ns = 32'h2000_0500;
        make_frame(70);
        set_ptp(PTP_DELAY_REQ);
        set_stamp(32'h1fff_f123);
        queue_frame(1'b1);
        exp_delay.req_ns = 32'h2000_0500 - 32'h1fff_f123;
        check_burst(frame_buf);
        compare_delay("counter_delay", exp_delay, counter_delay);
        // follow_up and plain frames leave both fields alone
        next_cycle();
        counter_ns = 32'h7777_0000;
        make_frame(64);
        set_ptp(PTP_FOLLOW_UP);
        set_stamp(32'h0000_0042);
        queue_frame(1'b0);
        check_burst(frame_buf);
        compare_delay("counter_delay", exp_delay, counter_delay);
        make_frame(64);
        frame_buf[14] = {4'h0, PTP_SYNC};  // only the ethertype keeps it out
        set_stamp(32'h0123_4567);
        queue_frame(1'b0);
        check_burst(frame_buf);
        compare_delay("counter_delay", exp_delay, counter_delay);
    endtask

    initial begin
        rstn_mac         = 1'b0;
        ptr_fifo_din     = '0;
        tptr_fifo_din    = '0;
        ptr_fifo_empty   = 1'b1;
        tptr_fifo_empty  = 1'b1;
        data_fifo_din    = '0;
        tdata_fifo_din   = '0;
        data_fifo_empty  = 1'b1;
        tdata_fifo_empty = 1'b1;
        counter_ns       = '0;
        exp_delay        = '0;
        repeat (10) @(posedge tx_master_clk);
        #5;
        rstn_mac = 1'b1;

        test_single_frame();
        test_tte_priority();
        test_back_to_back();
        test_ptp_sync();
        test_ptp_delay_req();
        compare_count("spare bursts", 0, burst_len.size());

        $display("Everything OK");
        $finish;
    end

endmodule

// File: design/mac_tx_top.sv
`timescale 1ns/100ps

module mac_tx_top (
    input  logic                   tx_master_clk,
    input  logic                   rstn_mac,
    // normal queue
    output logic                   ptr_fifo_rd,
    input  mac_tx_pkg::ptr_word_t  ptr_fifo_din,
    input  logic                   ptr_fifo_empty,
    output logic                   data_fifo_rd,
    input  mac_tx_pkg::byte_t      data_fifo_din,
    input  logic                   data_fifo_empty,
    // tte queue
    output logic                   tptr_fifo_rd,
    input  mac_tx_pkg::ptr_word_t  tptr_fifo_din,
    input  logic                   tptr_fifo_empty,
    output logic                   tdata_fifo_rd,
    input  mac_tx_pkg::byte_t      tdata_fifo_din,
    input  logic                   tdata_fifo_empty,
    // ptp and line side
    input  logic [31:0]            counter_ns,
    output mac_tx_pkg::ptp_delay_t counter_delay,
    output mac_tx_pkg::gmii_tx_t   gmii
);
    import mac_tx_pkg::*;

    tx_beat_t beat;     // to sender and ptp monitor
    logic     tx_busy;

    tx_queue_arbiter u_arbiter (
        .tx_master_clk    (tx_master_clk),
        .rstn_mac         (rstn_mac),
        .ptr_fifo_rd      (ptr_fifo_rd),
        .ptr_fifo_din     (ptr_fifo_din),
        .ptr_fifo_empty   (ptr_fifo_empty),
        .tptr_fifo_rd     (tptr_fifo_rd),
        .tptr_fifo_din    (tptr_fifo_din),
        .tptr_fifo_empty  (tptr_fifo_empty),
        .data_fifo_rd     (data_fifo_rd),
        .data_fifo_din    (data_fifo_din),
        .data_fifo_empty  (data_fifo_empty),
        .tdata_fifo_rd    (tdata_fifo_rd),
        .tdata_fifo_din   (tdata_fifo_din),
        .tdata_fifo_empty (tdata_fifo_empty),
        .tx_busy          (tx_busy),
        .beat             (beat)
    );

    tx_frame_sender u_sender (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .beat          (beat),
        .tx_busy       (tx_busy),
        .gmii          (gmii)
    );

    ptp_tx_monitor u_ptp_mon (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .beat          (beat),
        .counter_ns    (counter_ns),
        .counter_delay (counter_delay)
    );

endmodule

// File: design/ptp_tx_monitor.sv
`timescale 1ns/100ps

module ptp_tx_monitor (
    input  logic                   tx_master_clk,
    input  logic                   rstn_mac,
    input  mac_tx_pkg::tx_beat_t   beat,
    input  logic [31:0]            counter_ns,
    output mac_tx_pkg::ptp_delay_t counter_delay
);
    import mac_tx_pkg::*;

    ptp_state_e  state;
    ptp_msg_e    msg;
    logic        is_req;    // delay_req, else sync
    logic [23:0] ts_q;      // upper three ns bytes
    logic [31:0] now_q;     // counter_ns at first ts byte
    logic [31:0] delay_ns;
    logic        in_ts;
    logic        upd;

    assign msg      = ptp_msg_e'(beat.data[3:0]);
    assign in_ts    = beat.index >= frame_len_t'(PTP_TS_IDX) &&
                      beat.index <  frame_len_t'(PTP_TS_IDX + 3);
    assign upd      = (state == PTP_STAMP) && beat.valid &&
                      beat.index == frame_len_t'(PTP_TS_IDX + 3);
    assign delay_ns = now_q - {ts_q, beat.data};    // wraps mod 2^32

    always_ff @(posedge tx_master_clk) begin
        if (state == PTP_STAMP && beat.valid) begin
            if (in_ts)
                ts_q <= {ts_q[15:0], beat.data};
            if (beat.index == frame_len_t'(PTP_TS_IDX))
                now_q <= counter_ns;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // header parser
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state         <= PTP_HUNT;
            is_req        <= 1'b0;
            counter_delay <= '0;
        end else if (beat.valid) begin
            case (state)
                PTP_HUNT: begin
                    if (beat.index == frame_len_t'(PTP_TYPE_IDX - 2) &&
                        beat.data == PTP_ETYPE_HI)
                        state <= PTP_ETYPE;
                end
                PTP_ETYPE: begin
                    if (beat.index == frame_len_t'(PTP_TYPE_IDX - 1) &&
                        beat.data == PTP_ETYPE_LO)
                        state <= PTP_MSG;
                    else
                        state <= PTP_HUNT;
                end
                PTP_MSG: begin
                    is_req <= (msg == PTP_DELAY_REQ);
                    case (msg)
                        PTP_SYNC, PTP_DELAY_REQ:      state <= PTP_STAMP;
                        PTP_FOLLOW_UP, PTP_DELAY_RESP: state <= PTP_HUNT;  // general msgs
                        default:                       state <= PTP_HUNT;
                    endcase
                end
                PTP_STAMP: begin
                    if (upd) begin
                        if (is_req)
                            counter_delay.req_ns <= delay_ns;
                        else
                            counter_delay.sync_ns <= delay_ns;
                        state <= PTP_HUNT;
                    end
                end
                default: state <= PTP_HUNT;
            endcase
            // frame boundary always restarts the hunt
            if (beat.first || beat.last)
                state <= PTP_HUNT;
        end
    end

    a_no_upd_hunt : assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        !$stable(counter_delay) |-> $past(state) != PTP_HUNT);

endmodule

// File: design/tx_frame_sender.sv
`timescale 1ns/100ps

module tx_frame_sender (
    input  logic                 tx_master_clk,
    input  logic                 rstn_mac,
    input  mac_tx_pkg::tx_beat_t beat,
    output logic                 tx_busy,
    output mac_tx_pkg::gmii_tx_t gmii
);
    import mac_tx_pkg::*;

    send_state_e              state;
    logic [3:0]               cnt;        // tail, crc and gap counter
    byte_t [PREAMBLE_LEN-1:0] line;       // line[0] goes out next
    byte_t                    crc_byte;
    logic                     crc_shift;
    logic                     start;

    assign start     = beat.valid && beat.first;
    assign tx_busy   = (state != SEND_IDLE) || beat.valid;
    assign crc_shift = (state == SEND_CRC);

    ////////////////////////////////////////////////////////////////////
    // 8 byte delay line, holds preamble + sfd while idle
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge tx_master_clk) begin
        if (state == SEND_IDLE && !start)
            line <= {SFD_BYTE, {(PREAMBLE_LEN-1){PREAMBLE_BYTE}}};
        else
            line <= {beat.data, line[PREAMBLE_LEN-1:1]};
    end

    ////////////////////////////////////////////////////////////////////
    // output fsm
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state <= SEND_IDLE;
            cnt   <= '0;
            gmii  <= '0;
        end else begin
            case (state)
                SEND_IDLE: begin
                    if (start) begin
                        gmii.dv <= 1'b1;
                        gmii.d  <= line[0];
                        cnt     <= '0;
                        state   <= SEND_STREAM;
                    end
                end
                SEND_STREAM: begin
                    gmii.d <= line[0];
                    if (beat.valid) begin
                        cnt <= '0;
                    end else if (cnt == 4'(PREAMBLE_LEN - 1)) begin
                        cnt   <= '0;   // line drained
                        state <= SEND_CRC;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SEND_CRC: begin
                    gmii.d <= crc_byte;     // low byte first
                    cnt    <= cnt + 1'b1;
                    if (cnt == 4'(CRC_LEN - 1)) begin
                        cnt   <= '0;
                        state <= SEND_GAP;
                    end
                end
                SEND_GAP: begin
                    gmii.dv <= 1'b0;
                    gmii.d  <= '0;
                    cnt     <= cnt + 1'b1;
                    if (cnt == 4'(IFG_LEN - 1))
                        state <= SEND_IDLE;
                end
                default: state <= SEND_IDLE;
            endcase
        end
    end

    // crc runs on payload beats only, preamble never enters it
    crc32_gen u_crc32_gen (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .load_init     (start),
        .calc          (beat.valid),
        .shift         (crc_shift),
        .d             (beat.data),
        .crc_byte      (crc_byte)
    );

    a_dv_stream : assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        state == SEND_STREAM |=> gmii.dv);

endmodule

// File: design/tx_queue_arbiter.sv
`timescale 1ns/100ps

module tx_queue_arbiter (
    input  logic                  tx_master_clk,
    input  logic                  rstn_mac,
    output logic                  ptr_fifo_rd,
    input  mac_tx_pkg::ptr_word_t ptr_fifo_din,
    input  logic                  ptr_fifo_empty,
    output logic                  tptr_fifo_rd,
    input  mac_tx_pkg::ptr_word_t tptr_fifo_din,
    input  logic                  tptr_fifo_empty,
    output logic                  data_fifo_rd,
    input  mac_tx_pkg::byte_t     data_fifo_din,
    input  logic                  data_fifo_empty,
    output logic                  tdata_fifo_rd,
    input  mac_tx_pkg::byte_t     tdata_fifo_din,
    input  logic                  tdata_fifo_empty,
    input  logic                  tx_busy,
    output mac_tx_pkg::tx_beat_t  beat
);
    import mac_tx_pkg::*;

    arb_state_e state;
    logic       sel_tte;    // queue of the frame in flight
    frame_len_t len_q;
    frame_len_t rd_cnt;     // data strobes issued so far
    logic       data_rd;
    logic       rd_last;
    logic       rd_q;       // fifo word valid this cycle
    logic       first_q;
    logic       last_q;
    frame_len_t idx_q;

    assign ptr_fifo_rd   = (state == ARB_PTR_RD) && !sel_tte;
    assign tptr_fifo_rd  = (state == ARB_PTR_RD) && sel_tte;
    assign data_rd       = (state == ARB_DATA);
    assign data_fifo_rd  = data_rd && !sel_tte;
    assign tdata_fifo_rd = data_rd && sel_tte;
    assign rd_last       = data_rd && (rd_cnt == len_q - 1'b1);

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state   <= ARB_IDLE;
            sel_tte <= 1'b0;
            len_q   <= '0;
            rd_cnt  <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (!tx_busy && (!tptr_fifo_empty || !ptr_fifo_empty)) begin
                        sel_tte <= !tptr_fifo_empty;   // tte wins
                        state   <= ARB_PTR_RD;
                    end
                end
                ARB_PTR_RD: state <= ARB_PTR_LATCH;
                ARB_PTR_LATCH: begin
                    len_q  <= sel_tte ? tptr_fifo_din.len : ptr_fifo_din.len;
                    rd_cnt <= '0;
                    state  <= ARB_DATA;
                end
                ARB_DATA: begin
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_last)
                        state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // beat flags trail the strobe by one cycle, same as fifo data
    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            rd_q    <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
            idx_q   <= '0;
        end else begin
            rd_q    <= data_rd;
            first_q <= data_rd && (rd_cnt == '0);
            last_q  <= rd_last;
            idx_q   <= rd_cnt;
        end
    end

    always_comb begin
        beat.valid = rd_q;
        beat.first = first_q;
        beat.last  = last_q;
        beat.index = idx_q;
        beat.data  = sel_tte ? tdata_fifo_din : data_fifo_din;
    end

    // upstream writes the pointer only after the whole frame
    a_no_read_empty : assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        data_rd |-> !(sel_tte ? tdata_fifo_empty : data_fifo_empty));

    a_ptr_pulse : assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        (ptr_fifo_rd || tptr_fifo_rd) |->
            !(ptr_fifo_rd && tptr_fifo_rd) ##1 !(ptr_fifo_rd || tptr_fifo_rd));

    a_len_nonzero : assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        state == ARB_PTR_LATCH |=> len_q != '0);

endmodule

// File: design/crc32_gen.sv
`timescale 1ns/100ps

module crc32_gen (
    input  logic              tx_master_clk,
    input  logic              rstn_mac,
    input  logic              load_init,
    input  logic              calc,
    input  logic              shift,
    input  mac_tx_pkg::byte_t d,
    output mac_tx_pkg::byte_t crc_byte
);
    import mac_tx_pkg::*;

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // one byte, lsb first; init and calc together start a new frame
    always_comb begin
        crc_next = (load_init ? CRC_INIT : crc_q) ^ {24'h0, d};
        for (int i = 0; i < BYTE_W; i++) begin
            crc_next = crc_next[0] ? ((crc_next >> 1) ^ CRC_POLY) : (crc_next >> 1);
        end
    end

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac)
            crc_q <= CRC_INIT;
        else if (calc)
            crc_q <= crc_next;
        else if (load_init)
            crc_q <= CRC_INIT;
        else if (shift)
            crc_q <= {8'h00, crc_q[31:8]};  // next byte down
    end

    assign crc_byte = ~crc_q[7:0];

endmodule

// File: design/mac_tx_pkg.sv
package mac_tx_pkg;

    ////////////////////////////////////////////////////////////////////
    // widths and frame constants
    ////////////////////////////////////////////////////////////////////
    localparam int          BYTE_W        = 8;
    localparam int          LEN_W         = 11;
    localparam int          PTR_W         = 16;
    localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0]  SFD_BYTE      = 8'hd5;
    localparam int          PREAMBLE_LEN  = 8;       // 7 preamble + sfd
    localparam int          CRC_LEN       = 4;
    localparam int          IFG_LEN       = 12;      // idle cycles between bursts
    localparam logic [7:0]  PTP_ETYPE_HI  = 8'h88;   // frame byte 12
    localparam logic [7:0]  PTP_ETYPE_LO  = 8'hf7;   // frame byte 13
    localparam int          PTP_TYPE_IDX  = 14;      // low nibble is messageType
    localparam int          PTP_TS_IDX    = 54;      // originTimestamp ns, big endian
    localparam logic [31:0] CRC_INIT      = 32'hffff_ffff;
    localparam logic [31:0] CRC_POLY      = 32'hedb8_8320;  // 802.3, reflected

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [LEN_W-1:0]  frame_len_t;

    typedef struct packed {
        logic [PTR_W-LEN_W-1:0] rsvd;   // ignored
        frame_len_t             len;    // bytes without crc
    } ptr_word_t;

    typedef enum logic [3:0] {
        PTP_SYNC       = 4'h0,
        PTP_DELAY_REQ  = 4'h1,
        PTP_FOLLOW_UP  = 4'h8,
        PTP_DELAY_RESP = 4'h9
    } ptp_msg_e;

    typedef struct packed {
        logic       valid;
        logic       first;
        logic       last;
        frame_len_t index;  // 0-based byte position
        byte_t      data;
    } tx_beat_t;

    typedef struct packed {
        logic  dv;
        byte_t d;
    } gmii_tx_t;

    typedef struct packed {
        logic [31:0] req_ns;
        logic [31:0] sync_ns;
    } ptp_delay_t;

    ////////////////////////////////////////////////////////////////////
    // fsm encodings
    ////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {ARB_IDLE, ARB_PTR_RD, ARB_PTR_LATCH, ARB_DATA} arb_state_e;
    typedef enum logic [1:0] {SEND_IDLE, SEND_STREAM, SEND_CRC, SEND_GAP} send_state_e;
    typedef enum logic [1:0] {PTP_HUNT, PTP_ETYPE, PTP_MSG, PTP_STAMP} ptp_state_e;

endpackage
